/* common/matrix_macros.svh */
`ifndef MATRIX_MACROS_SVH
`define MATRIX_MACROS_SVH

// square matrix, rows and columns alike
`define MATRIX_ROWS 8

// glyph numbers 0 to 15
`define MATRIX_GLYPHS 16

// clock cycles per row period, 4 or more
`define MATRIX_SCAN_DIV 8

`endif

/* common/matrix_pkg.sv */
`default_nettype none

`include "matrix_macros.svh"

package matrix_pkg;

    // index of one matrix row
    typedef logic [$clog2(`MATRIX_ROWS)-1:0] row_idx_t;

    // bit i lights column i
    typedef logic [`MATRIX_ROWS-1:0] col_bits_t;

    // active low, all ones selects no row
    typedef logic [`MATRIX_ROWS-1:0] row_sel_t;

    typedef logic [$clog2(`MATRIX_GLYPHS)-1:0] glyph_num_t;

endpackage

`default_nettype wire

/* common/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // loader copy sequence
    typedef enum logic [1:0]
    {
        IDLE,
        REQ,    // fetch first row from rom
        WRITE   // one buffer write per granted cycle
    } loader_state_t;

    // owner of the frame buffer port
    typedef enum logic [1:0]
    {
        NONE,
        SCAN,
        LOAD
    } grant_t;

endpackage

`default_nettype wire

/* src/glyph_rom.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matrix_macros.svh"

module glyph_rom
(
    input  wire matrix_pkg::glyph_num_t glyph,
    input  wire matrix_pkg::row_idx_t   row_idx,
    output matrix_pkg::col_bits_t       pattern
);

    import matrix_pkg::*;

    localparam glyph_num_t GAUGE_LAST = glyph_num_t'(`MATRIX_ROWS);
    localparam glyph_num_t FRAME_NUM  = glyph_num_t'(`MATRIX_ROWS + 1);
    localparam row_idx_t   ROW_LAST   = row_idx_t'(`MATRIX_ROWS - 1);

    // only the two outer columns of a frame side row
    localparam col_bits_t EDGE_COLS =
        col_bits_t'(1) | (col_bits_t'(1) << (`MATRIX_ROWS - 1));

    logic gauge_lit;
    logic frame_rim;

    // gauge n fills rows 8-n to 7
    always_comb
    begin
        gauge_lit = (int'(glyph) + int'(row_idx)) >= `MATRIX_ROWS;
    end

    always_comb
    begin
        frame_rim = (row_idx == '0) || (row_idx == ROW_LAST);
    end

    always_comb
    begin
        pattern = '0;
        if (glyph <= GAUGE_LAST)
        begin
            if (gauge_lit)
            begin
                pattern = '1;
            end
        end
        else if (glyph == FRAME_NUM)
        begin
            if (frame_rim)
            begin
                pattern = '1;       // top and bottom bars
            end
            else
            begin
                pattern = EDGE_COLS;
            end
        end
        else
        begin
            pattern = '0;           // unused numbers stay dark
        end
    end

endmodule

`default_nettype wire

/* src/buffer_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module buffer_arbiter
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         scan_req,
    input  wire matrix_pkg::row_idx_t   scan_row,
    input  wire                         load_req,
    input  wire matrix_pkg::row_idx_t   load_row,
    input  wire matrix_pkg::col_bits_t  load_data,
    output logic                        scan_gnt,
    output logic                        load_gnt,
    output matrix_pkg::row_idx_t        addr,
    output matrix_pkg::col_bits_t       wdata,
    output logic                        we,
    output logic                        re
);

    import ctrl_pkg::*;

    grant_t last_gnt;

    // scanner first, loader takes any free cycle
    assign scan_gnt = scan_req;
    assign load_gnt = load_req && !scan_req;

    assign addr  = scan_gnt ? scan_row : load_row;
    assign wdata = load_data;
    assign we    = load_gnt;
    assign re    = scan_gnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            last_gnt <= NONE;
        end
        else if (scan_gnt)
        begin
            last_gnt <= SCAN;   // rdata belongs to the scanner next cycle
        end
        else if (load_gnt)
        begin
            last_gnt <= LOAD;
        end
        else
        begin
            last_gnt <= NONE;
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(scan_gnt && load_gnt));

    // a scanner read must not be overwritten before the scanner takes it
    a_read_spacing: assert property (@(posedge clk) disable iff (rst)
        (last_gnt == SCAN) |-> !scan_req);

endmodule

`default_nettype wire

/* display/frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matrix_macros.svh"

module frame_buffer
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire matrix_pkg::row_idx_t   addr,
    input  wire matrix_pkg::col_bits_t  wdata,
    input  wire                         we,
    input  wire                         re,
    output matrix_pkg::col_bits_t       rdata
);

    import matrix_pkg::*;

    col_bits_t mem [`MATRIX_ROWS];

    // blank picture after reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `MATRIX_ROWS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (we)
        begin
            mem[addr] <= wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (re)
        begin
            rdata <= mem[addr];     // valid the cycle after re
        end
    end

endmodule

`default_nettype wire

/* display/row_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matrix_macros.svh"

module row_scanner
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         st,
    input  wire                         temp,
    output logic                        scan_req,
    output matrix_pkg::row_idx_t        scan_row,
    input  wire                         scan_gnt,
    input  wire matrix_pkg::col_bits_t  rdata,
    output matrix_pkg::row_sel_t        row,
    output matrix_pkg::col_bits_t       colg,
    output matrix_pkg::col_bits_t       colr
);

    import matrix_pkg::*;

    localparam int CNT_W = $clog2(`MATRIX_SCAN_DIV);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MATRIX_SCAN_DIV - 1);

    logic [CNT_W-1:0] cnt;
    row_idx_t         row_cnt;
    logic             active;      // one cycle behind st, restart at count 0
    logic             rd_pending;
    logic             temp_meta;
    logic             alarm;
    row_sel_t         row_q;
    col_bits_t        colg_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            active  <= 1'b0;
            cnt     <= '0;
            row_cnt <= '0;
        end
        else if (!st)
        begin
            active  <= 1'b0;
            cnt     <= '0;
            row_cnt <= '0;
        end
        else
        begin
            active <= 1'b1;
            if (active)
            begin
                if (cnt == CNT_LAST)
                begin
                    cnt     <= '0;
                    row_cnt <= row_cnt + row_idx_t'(1);
                end
                else
                begin
                    cnt <= cnt + CNT_W'(1);
                end
            end
        end
    end

    // fetch on count 0
    assign scan_req = st && active && (cnt == '0);
    assign scan_row = row_cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rd_pending <= 1'b0;
        end
        else
        begin
            rd_pending <= scan_gnt;
        end
    end

    // rdata arrives on count 1, shown from count 2
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_q  <= '1;
            colg_q <= '0;
        end
        else if (!st)
        begin
            row_q  <= '1;
            colg_q <= '0;
        end
        else if (rd_pending)
        begin
            row_q  <= ~(row_sel_t'(1) << row_cnt);
            colg_q <= rdata;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            temp_meta <= 1'b0;
            alarm     <= 1'b0;
        end
        else
        begin
            temp_meta <= temp;
            alarm     <= temp_meta;
        end
    end

    assign row  = st ? row_q : '1;     // blank at once when st drops
    assign colg = st ? colg_q : '0;
    assign colr = alarm ? colg : '0;   // red over green shows orange

    a_one_row: assert property (@(posedge clk) disable iff (rst)
        $countones(~row) <= 1);

    // buffer read latency lines up with the period counter
    a_read_return: assert property (@(posedge clk) disable iff (rst)
        rd_pending && st |-> cnt == CNT_W'(1));

endmodule

`default_nettype wire

/* display/glyph_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matrix_macros.svh"

module glyph_loader
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire matrix_pkg::glyph_num_t num,
    input  wire                         num_valid,
    output matrix_pkg::glyph_num_t      rom_glyph,
    output matrix_pkg::row_idx_t        rom_row,
    input  wire matrix_pkg::col_bits_t  rom_pattern,
    output logic                        load_req,
    output matrix_pkg::row_idx_t        load_row,
    output matrix_pkg::col_bits_t       load_data,
    input  wire                         load_gnt
);

    import matrix_pkg::*;
    import ctrl_pkg::*;

    localparam row_idx_t ROW_LAST = row_idx_t'(`MATRIX_ROWS - 1);

    loader_state_t state;
    glyph_num_t    glyph_q;
    row_idx_t      row_q;
    col_bits_t     data_q;

    // a new strobe always restarts at row 0
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= IDLE;
            row_q <= '0;
        end
        else if (num_valid)
        begin
            state <= REQ;
            row_q <= '0;
        end
        else
        begin
            case (state)
                REQ:
                begin
                    state <= WRITE;
                end
                WRITE:
                begin
                    if (load_gnt)
                    begin
                        if (row_q == ROW_LAST)
                        begin
                            state <= IDLE;
                        end
                        else
                        begin
                            row_q <= row_q + row_idx_t'(1);
                        end
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (num_valid)
        begin
            glyph_q <= num;
        end
    end

    // write data registered, rom looks one row ahead while writing
    always_ff @(posedge clk)
    begin
        if ((state == REQ) || ((state == WRITE) && load_gnt))
        begin
            data_q <= rom_pattern;
        end
    end

    assign rom_glyph = glyph_q;
    assign rom_row   = (state == WRITE) ? row_q + row_idx_t'(1) : row_q;

    assign load_req  = (state == WRITE);
    assign load_row  = row_q;
    assign load_data = data_q;

    a_req_held: assert property (@(posedge clk) disable iff (rst)
        load_req && !load_gnt && !num_valid |=> load_req && $stable(load_row));

endmodule

`default_nettype wire

/* src/matrix_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module matrix_display_top
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire matrix_pkg::glyph_num_t num,
    input  wire                         num_valid,
    input  wire                         st,
    input  wire                         temp,
    output wire matrix_pkg::row_sel_t   row,
    output wire matrix_pkg::col_bits_t  colg,
    output wire matrix_pkg::col_bits_t  colr
);

    import matrix_pkg::*;

    glyph_num_t rom_glyph;
    row_idx_t   rom_row;
    col_bits_t  rom_pattern;

    logic       load_req;
    row_idx_t   load_row;
    col_bits_t  load_data;
    logic       load_gnt;

    logic       scan_req;
    row_idx_t   scan_row;
    logic       scan_gnt;

    row_idx_t   buf_addr;
    col_bits_t  buf_wdata;
    logic       buf_we;
    logic       buf_re;
    col_bits_t  buf_rdata;

    glyph_loader u_loader (
        .clk         (clk),
        .rst         (rst),
        .num         (num),
        .num_valid   (num_valid),
        .rom_glyph   (rom_glyph),
        .rom_row     (rom_row),
        .rom_pattern (rom_pattern),
        .load_req    (load_req),
        .load_row    (load_row),
        .load_data   (load_data),
        .load_gnt    (load_gnt)
    );

    glyph_rom u_rom (
        .glyph   (rom_glyph),
        .row_idx (rom_row),
        .pattern (rom_pattern)
    );

    buffer_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .scan_req  (scan_req),
        .scan_row  (scan_row),
        .load_req  (load_req),
        .load_row  (load_row),
        .load_data (load_data),
        .scan_gnt  (scan_gnt),
        .load_gnt  (load_gnt),
        .addr      (buf_addr),
        .wdata     (buf_wdata),
        .we        (buf_we),
        .re        (buf_re)
    );

    frame_buffer u_buf (
        .clk   (clk),
        .rst   (rst),
        .addr  (buf_addr),
        .wdata (buf_wdata),
        .we    (buf_we),
        .re    (buf_re),
        .rdata (buf_rdata)
    );

    row_scanner u_scan (
        .clk      (clk),
        .rst      (rst),
        .st       (st),
        .temp     (temp),
        .scan_req (scan_req),
        .scan_row (scan_row),
        .scan_gnt (scan_gnt),
        .rdata    (buf_rdata),
        .row      (row),
        .colg     (colg),
        .colr     (colr)
    );

endmodule

`default_nettype wire

/* testbench/tb_matrix_display.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matrix_macros.svh"

module tb_matrix_display;

    import matrix_pkg::*;

    localparam int  CLK_PERIOD   = 4;
    localparam int  ROWS         = `MATRIX_ROWS;
    localparam int  FRAME_CYCLES = `MATRIX_ROWS * `MATRIX_SCAN_DIV;
    localparam int  TEST_FRAMES  = 2 + 32 + 4 + 4 + 3 + 80;   // frames of each test in order
    localparam int  WATCHDOG_CYCLES = TEST_FRAMES * FRAME_CYCLES + 16 + 500;

    logic       clk;
    logic       rst;
    glyph_num_t num;
    logic       num_valid;
    logic       st;
    logic       temp;
    row_sel_t   row;
    col_bits_t  colg;
    col_bits_t  colr;

    logic [15:0] lfsr;
    glyph_num_t  cur_glyph;     // glyph 0 is as dark as a cleared buffer
    logic        cur_temp;
    time         settled_from;
    row_sel_t    prev_row;
    int          next_idx;
    int          seen_idx;
    col_bits_t   exp_g;
    col_bits_t   exp_r;
    int          errors;
    int          checks;
    int          test_errors0;
    int          test_checks0;
    logic [3:0]  rnd;

    matrix_display_top uut (
        .clk       (clk),
        .rst       (rst),
        .num       (num),
        .num_valid (num_valid),
        .st        (st),
        .temp      (temp),
        .row       (row),
        .colg      (colg),
        .colr      (colr)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic col_bits_t glyph_ref(input glyph_num_t g, input int r);
        col_bits_t p;
        p = '0;
        if (int'(g) <= ROWS)
        begin
            if (r >= ROWS - int'(g))
            begin
                p = '1;     // gauge fill from the bottom
            end
        end
        else if (int'(g) == ROWS + 1)
        begin
            if ((r == 0) || (r == ROWS - 1))
            begin
                p = '1;
            end
            else
            begin
                p[0]        = 1'b1;
                p[ROWS - 1] = 1'b1;
            end
        end
        return p;
    endfunction

    // index of the single low bit or -1
    function automatic int zero_index(input row_sel_t s);
        int idx;
        int zeros;
        idx   = -1;
        zeros = 0;
        for (int i = 0; i < ROWS; i++)
        begin
            if (!s[i])
            begin
                zeros++;
                idx = i;
            end
        end
        if (zeros != 1)
        begin
            idx = -1;
        end
        return idx;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [3:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[2:0], lfsr[0]};
        end
    endtask

    task automatic mark_change();
        settled_from = $time + FRAME_CYCLES * CLK_PERIOD;
    endtask

    task automatic load_glyph(input glyph_num_t g);
        @(posedge clk);
        #1;
        num       = g;
        num_valid = 1'b1;
        cur_glyph = g;
        mark_change();
        @(posedge clk);
        #1;
        num_valid = 1'b0;
    endtask

    task automatic set_temp(input logic t);
        @(posedge clk);
        #1;
        temp     = t;
        cur_temp = t;
        mark_change();
    endtask

    task automatic wait_frames(input int n);
        repeat (n * FRAME_CYCLES) @(posedge clk);
    endtask

    task automatic start_test();
        test_errors0 = errors;
        test_checks0 = checks;
    endtask

    task automatic end_test(input string name);
        if (checks == test_checks0)
        begin
            $display("%s: no rows were compared", name);
            errors++;
        end
        $display("%s: %0d rows compared, %0d errors", name,
                 checks - test_checks0, errors - test_errors0);
    endtask

    task automatic check_blank(input int n);
        repeat (n)
        begin
            @(negedge clk);
            if (row !== '1)
            begin
                $display("ERROR %0t row expected %h got %h", $time, {ROWS{1'b1}}, row);
                errors++;
            end
            if (colg !== '0)
            begin
                $display("ERROR %0t colg expected %h got %h", $time, 8'h00, colg);
                errors++;
            end
            if (colr !== '0)
            begin
                $display("ERROR %0t colr expected %h got %h", $time, 8'h00, colr);
                errors++;
            end
        end
    endtask

    // compare each newly selected row at the falling edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            prev_row = '1;
            next_idx = 0;
        end
        else if (row !== prev_row)
        begin
            prev_row = row;
            seen_idx = zero_index(row);
            if (seen_idx >= 0)
            begin
                if (seen_idx != next_idx)
                begin
                    $display("ERROR %0t row index expected %0d got %0d",
                             $time, next_idx, seen_idx);
                    errors++;
                end
                next_idx = (seen_idx + 1) % ROWS;
                if ($time >= settled_from)
                begin
                    exp_g = glyph_ref(cur_glyph, seen_idx);
                    exp_r = cur_temp ? exp_g : '0;
                    checks++;
                    if (colg !== exp_g)
                    begin
                        $display("ERROR %0t colg expected %h got %h", $time, exp_g, colg);
                        errors++;
                    end
                    if (colr !== exp_r)
                    begin
                        $display("ERROR %0t colr expected %h got %h", $time, exp_r, colr);
                        errors++;
                    end
                end
            end
            else if (row === '1)
            begin
                next_idx = 0;   // blanked so the scan restarts at row 0
            end
            else
            begin
                $display("row select at %0t has more than one active line: %b", $time, row);
                errors++;
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        rst          = 1'b1;
        st           = 1'b1;
        temp         = 1'b0;
        num          = '0;
        num_valid    = 1'b0;
        lfsr         = 16'd50718;
        cur_glyph    = '0;
        cur_temp     = 1'b0;
        settled_from = 0;
        prev_row     = '1;
        next_idx     = 0;
        errors       = 0;
        checks       = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test();
        wait_frames(2);
        end_test("test 1 blank after reset");

        start_test();
        for (int g = 0; g < `MATRIX_GLYPHS; g++)
        begin
            load_glyph(glyph_num_t'(g));
            wait_frames(2);
        end
        end_test("test 2 all glyphs");

        start_test();
        load_glyph(glyph_num_t'(9));
        set_temp(1'b1);
        wait_frames(2);
        set_temp(1'b0);
        wait_frames(2);
        end_test("test 3 temperature alarm");

        start_test();
        set_temp(1'b1);     // red plane lit so blanking covers colr too
        wait_frames(1);
        @(posedge clk);
        #1;
        st = 1'b0;
        check_blank(FRAME_CYCLES);
        @(posedge clk);
        #1;
        st = 1'b1;
        wait_frames(2);
        end_test("test 4 blanking");

        start_test();
        load_glyph(glyph_num_t'(9));
        repeat (3) @(posedge clk);
        load_glyph(glyph_num_t'(5));    // lands in the middle of the first copy
        wait_frames(2);
        end_test("test 5 restarted copy");

        start_test();
        for (int i = 0; i < 40; i++)
        begin
            take_bits(4, rnd);
            load_glyph(glyph_num_t'(rnd));
            take_bits(1, rnd);
            set_temp(rnd[0]);
            wait_frames(2);
        end
        end_test("test 6 random glyphs");

        $display("%0d rows compared, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+common
common/matrix_pkg.sv
common/ctrl_pkg.sv
src/glyph_rom.sv
src/buffer_arbiter.sv
display/frame_buffer.sv
display/row_scanner.sv
display/glyph_loader.sv
src/matrix_display_top.sv
testbench/tb_matrix_display.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module tb_matrix_display \
		-Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Test OK" sim.log

lint:
	verilator --lint-only --timing -f filelist.f --top-module tb_matrix_display

clean:
	rm -rf obj_dir sim.log
